// File: hw/decode_execute_if.sv
/* decoded instruction from the decode register to execute and result
   result returns accept when its output register can take the word */
`timescale 1ns/1ps

interface decode_execute_if
  import frontend_pkg::*;
();

  logic     valid;
  addr_t    pc;
  addr_t    pc4;
  word_t    instr;
  // jal fields, only meaningful with is_jal
  logic     is_jal;
  reg_idx_t rd;
  word_t    jal_imm;
  logic     mal_insn;
  // result register empty or being drained this cycle
  logic     accept;

  modport decode (
    output valid, pc, pc4, instr, is_jal, rd, jal_imm, mal_insn,
    input  accept
  );

  // execute only observes, it owns no state
  modport execute (
    input valid, pc, pc4, is_jal, rd, jal_imm, accept
  );

  modport result (
    input  valid, pc, instr, is_jal, mal_insn,
    output accept
  );

endinterface

// File: hw/fetch_decode_if.sv
/* fetch/decode latch contents, driven by fetch and consumed by decode
   decode answers with hold while it cannot take a new word */
`timescale 1ns/1ps

interface fetch_decode_if
  import frontend_pkg::*;
();

  // latch holds a word or a misaligned token
  logic  valid;
  addr_t pc;
  addr_t pc4;
  word_t instr;
  // fetch address was not word aligned, instr is zero
  logic  mal_insn;
  // decode is stalled, latch keeps its contents
  logic  hold;

  modport fetch (
    output valid, pc, pc4, instr, mal_insn,
    input  hold
  );

  modport decode (
    input  valid, pc, pc4, instr, mal_insn,
    output hold
  );

endinterface

// File: hw/fetch_stage.sv
/* program counter, next-pc selection, wishbone classic read master
   and the fetch/decode latch, one bus cycle outstanding at most */
`timescale 1ns/1ps

module fetch_stage
  import frontend_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  redirect,
  input  addr_t redirect_pc,
  input  word_t wb_dat_r,
  input  logic  wb_ack,
  output addr_t wb_adr,
  output logic  wb_cyc,
  output logic  wb_stb,
  fetch_decode_if.fetch fd
);

  // pc is the next address to fetch, wb_adr the one on the bus
  addr_t pc;
  addr_t pc4;
  addr_t next_pc;
  addr_t slot_pc;
  word_t instr;
  // bus cycle overtaken by a redirect or halt, drop its data
  logic  discard;
  // misaligned token placed, wait for halt
  logic  idle;
  logic  aligned;
  logic  latch_free;
  logic  start;
  logic  mal_take;
  logic  ack_take;

  assign pc4     = pc + 32'd4;
  assign aligned = (pc[1:0] == 2'b00);

  // latch is empty or decode takes it at this edge
  assign latch_free = ~fd.valid | ~fd.hold;

  // new bus cycle only from a quiet bus and a stable pc
  assign start    = ~wb_cyc & ~idle & aligned & latch_free & ~halt & ~redirect;
  // misaligned pc never reaches the bus
  assign mal_take = ~wb_cyc & ~idle & ~aligned & latch_free & ~halt & ~redirect;
  // completed read that is still on the right path
  assign ack_take = wb_cyc & wb_ack & ~discard & ~halt & ~redirect;

  // stb follows cyc, classic single reads only
  assign wb_stb = wb_cyc;

  // byte order swap of the read data
  assign instr = BUS_LITTLE_ENDIAN ?
                 {wb_dat_r[7:0], wb_dat_r[15:8], wb_dat_r[23:16], wb_dat_r[31:24]} :
                 wb_dat_r;

  // bus address while a read is out, else the pc of a token
  assign slot_pc = wb_cyc ? wb_adr : pc;

  // halt, then redirect, then sequential
  always_comb begin
    next_pc = pc;
    if (halt) begin
      next_pc = RESET_PC;
    end else if (redirect) begin
      next_pc = redirect_pc;
    end else if (start) begin
      next_pc = pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc      <= RESET_PC;
      wb_adr  <= RESET_PC;
      wb_cyc  <= 1'b0;
      discard <= 1'b0;
      idle    <= 1'b0;
    end else begin
      pc <= next_pc;
      if (wb_cyc) begin
        // cycle in flight always runs to its ack
        if (wb_ack) begin
          wb_cyc  <= 1'b0;
          discard <= 1'b0;
        end else if (halt | redirect) begin
          discard <= 1'b1;
        end
      end else if (start) begin
        wb_cyc <= 1'b1;
        wb_adr <= pc;
      end
      if (halt) begin
        idle <= 1'b0;
      end else if (mal_take) begin
        idle <= 1'b1;
      end
    end
  end

  // latch valid, wrong path dropped on redirect
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fd.valid <= 1'b0;
    end else if (halt | redirect) begin
      fd.valid <= 1'b0;
    end else if (!(fd.valid & fd.hold)) begin
      fd.valid <= ack_take | mal_take;
    end
  end

  // latch payload
  always_ff @(posedge CLK) begin
    if (ack_take | mal_take) begin
      fd.pc       <= slot_pc;
      fd.pc4      <= slot_pc + 32'd4;
      fd.instr    <= ack_take ? instr : '0;
      fd.mal_insn <= mal_take;
    end
  end

endmodule

// File: hw/frontend_pkg.sv
/* widths, typedefs and constants shared by the rv32i instruction front end
   imported by every stage and by the testbench reference model */
package frontend_pkg;

  // data or instruction word
  typedef logic [31:0] word_t;

  // byte address or program counter
  typedef logic [31:0] addr_t;

  // major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // restart address after reset and after halt
  localparam addr_t RESET_PC = 32'h200;

  // bus returns bytes in reversed order, fetch swaps them back
  // the testbench memory builds its read data with the same setting
  localparam logic BUS_LITTLE_ENDIAN = 1'b1;

  // jal, the only jump resolved by this front end
  localparam opcode_t OPCODE_JAL = 7'b1101111;

endpackage

// File: hw/frontend_top.sv
/* front end top level, wishbone instruction bus in, decoded stream out
   stages talk through interfaces, the outside sees plain ports */
`timescale 1ns/1ps

module frontend_top
  import frontend_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       halt,
  // wishbone classic, reads only
  output addr_t      wb_adr,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output logic [3:0] wb_sel,
  input  word_t      wb_dat_r,
  input  logic       wb_ack,
  // decoded instruction stream
  output logic       out_valid,
  input  logic       out_ready,
  output addr_t      out_pc,
  output word_t      out_instr,
  output word_t      out_link,
  output logic       out_jump,
  output logic       out_mal
);

  logic  redirect;
  addr_t redirect_pc;
  word_t link;

  fetch_decode_if   fd_if ();
  decode_execute_if de_if ();

  // whole words, never a write
  assign wb_we  = 1'b0;
  assign wb_sel = 4'b1111;

  fetch_stage u_fetch (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .wb_adr      (wb_adr),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .fd          (fd_if.fetch)
  );

  jal_decode u_decode (
    .CLK  (CLK),
    .nRST (nRST),
    .halt (halt),
    .fd   (fd_if.decode),
    .de   (de_if.decode)
  );

  jal_execute u_execute (
    .de          (de_if.execute),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .link        (link)
  );

  issue_result u_result (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .link      (link),
    .out_ready (out_ready),
    .de        (de_if.result),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_instr (out_instr),
    .out_link  (out_link),
    .out_jump  (out_jump),
    .out_mal   (out_mal)
  );

endmodule

// File: hw/issue_result.sv
/* one-entry output register toward the consumer, valid/ready handshake
   its accept is the stall source for the whole front end */
`timescale 1ns/1ps

module issue_result
  import frontend_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  word_t link,
  input  logic  out_ready,
  decode_execute_if.result de,
  output logic  out_valid,
  output addr_t out_pc,
  output word_t out_instr,
  output word_t out_link,
  output logic  out_jump,
  output logic  out_mal
);

  logic load;

  // empty, or the held word transfers at this edge
  assign de.accept = ~out_valid | out_ready;
  assign load      = de.accept & de.valid;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (halt) begin
      out_valid <= 1'b0;
    end else if (de.accept) begin
      out_valid <= de.valid;
    end
  end

  // data only moves with accept, stable under back-pressure
  always_ff @(posedge CLK) begin
    if (load) begin
      out_pc    <= de.pc;
      out_instr <= de.instr;
      out_link  <= link;
      out_jump  <= de.is_jal;
      out_mal   <= de.mal_insn;
    end
  end

endmodule

// File: hw/jal_decode.sv
/* decode register between the fetch latch and execute/result
   classifies the latched word and extracts the jal fields */
`timescale 1ns/1ps

module jal_decode
  import frontend_pkg::*;
(
  input  logic CLK,
  input  logic nRST,
  input  logic halt,
  fetch_decode_if.decode  fd,
  decode_execute_if.decode de
);

  opcode_t opcode;
  // full and result not taking it
  logic    stall;
  // own jal leaves for result, younger words are wrong path
  logic    flush;
  logic    load;

  assign opcode = fd.instr[6:0];
  assign stall  = de.valid & ~de.accept;
  assign flush  = de.valid & de.is_jal & de.accept;
  assign load   = ~stall & ~flush & fd.valid;

  // back-pressure to the fetch latch
  assign fd.hold = stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      de.valid <= 1'b0;
    end else if (halt | flush) begin
      de.valid <= 1'b0;
    end else if (!stall) begin
      de.valid <= fd.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      de.pc       <= fd.pc;
      de.pc4      <= fd.pc4;
      de.instr    <= fd.instr;
      de.mal_insn <= fd.mal_insn;
      // misaligned token carries instr zero, never a jal
      de.is_jal   <= (opcode == OPCODE_JAL);
      de.rd       <= fd.instr[11:7];
      // j-type immediate, bit 0 implied zero
      de.jal_imm  <= {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                      fd.instr[20], fd.instr[30:21], 1'b0};
    end
  end

endmodule

// File: hw/jal_execute.sv
/* jal resolution, jump target and link value for the decoded word
   redirect fires in the cycle the jal moves into the result register */
`timescale 1ns/1ps

module jal_execute
  import frontend_pkg::*;
(
  decode_execute_if.execute de,
  output logic  redirect,
  output addr_t redirect_pc,
  output word_t link
);

  // the only jump target adder in the front end
  addr_t target;

  assign target = de.pc + de.jal_imm;

  // target may be misaligned, fetch turns that into a token
  assign redirect_pc = target;

  // one pulse per jal, at the edge result takes it
  assign redirect = de.valid & de.is_jal & de.accept;

  // return address goes out with the jal itself
  assign link = de.is_jal ? de.pc4 : '0;

endmodule

// File: sources.f
hw/frontend_pkg.sv
hw/fetch_decode_if.sv
hw/decode_execute_if.sv
hw/fetch_stage.sv
hw/jal_decode.sv
hw/jal_execute.sv
hw/issue_result.sv
hw/frontend_top.sv
verification/frontend_assertions.sv
verification/frontend_tb.sv

// File: verification/frontend_assertions.sv
/* protocol checks on the wishbone master and the output handshake
   attached to every frontend_top instance by the bind at the bottom */
`timescale 1ns/1ps

module frontend_assertions
  import frontend_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  halt,
  input addr_t wb_adr,
  input logic  wb_cyc,
  input logic  wb_stb,
  input logic  wb_ack,
  input logic  out_valid,
  input logic  out_ready,
  input addr_t out_pc,
  input word_t out_instr,
  input word_t out_link,
  input logic  out_jump,
  input logic  out_mal
);

  // failed assertions so far
  int failures = 0;

  // cyc and stb move together and stay up with a stable address until ack
  bus_held: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
    else begin
      $error("wishbone cycle dropped or address changed before ack");
      failures++;
    end

  // halt empties the output register, so it is the only exception
  out_held: assert property (@(posedge CLK) disable iff (!nRST)
    (out_valid && !out_ready && !halt) |=>
    (out_valid && $stable(out_pc) && $stable(out_instr) && $stable(out_link)
     && $stable(out_jump) && $stable(out_mal)))
    else begin
      $error("output word changed or vanished before it was taken");
      failures++;
    end

  // quiet outputs when reset is released
  reset_quiet: assert property (@(posedge CLK) $rose(nRST) |-> (!out_valid && !wb_cyc))
    else begin
      $error("out_valid or wb_cyc high when reset was released");
      failures++;
    end

endmodule

bind frontend_top frontend_assertions u_assertions (
  .CLK (CLK), .nRST (nRST), .halt (halt),
  .wb_adr (wb_adr), .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_ack (wb_ack),
  .out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
  .out_instr (out_instr), .out_link (out_link), .out_jump (out_jump), .out_mal (out_mal)
);

// File: verification/frontend_tb.sv
/* directed testbench for frontend_top with a wishbone memory model
   a reference model follows the program and checks every output transfer */
`timescale 1ns/1ps

module frontend_tb
  import frontend_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  // 16 + 16 + 24 + 12 + 3 + 13 transfers over all tests
  localparam int TOTAL_XFERS     = 84;
  localparam int CYCLES_PER_XFER = 24;
  localparam int WATCHDOG_CYCLES = TOTAL_XFERS * CYCLES_PER_XFER + 300;

  logic  CLK, nRST, halt, out_ready, wb_ack;
  word_t wb_dat_r;
  addr_t wb_adr, out_pc;
  logic  wb_cyc, wb_stb, wb_we, out_valid, out_jump, out_mal;
  logic [3:0] wb_sel;
  word_t out_instr, out_link;

  string test_name;
  int    errors, checks, xfers, test_xfers;
  // reference model state
  addr_t model_pc;
  logic  model_done;
  // program overlay, jal words on top of the default fill
  addr_t jal_addr [4];
  word_t jal_imm [4];
  word_t jal_word [4];
  int    jal_count;
  // stimulus knobs
  int    max_wait, waits_left;
  logic  ready_random;
  word_t wait_rng, ready_rng;

  frontend_top dut (
    .CLK (CLK), .nRST (nRST), .halt (halt),
    .wb_adr (wb_adr), .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
    .wb_sel (wb_sel), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
    .out_instr (out_instr), .out_link (out_link), .out_jump (out_jump), .out_mal (out_mal)
  );

  function automatic word_t lcg_step(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // op-imm word, upper bits mixed from the whole address
  function automatic word_t default_word(input addr_t a);
    word_t mix;
    mix = (a ^ 32'h5bd1e995) * 32'h9e3779b1;
    return {mix[31:7], 7'b0010011};
  endfunction

  // j-type layout imm[20|10:1|11|19:12], rd, opcode
  function automatic word_t jal_encode(input reg_idx_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  function automatic int find_jal(input addr_t a);
    for (int i = 0; i < jal_count; i++) begin
      if (jal_addr[i] == a) return i;
    end
    return -1;
  endfunction

  function automatic word_t mem_word(input addr_t a);
    int idx;
    idx = find_jal(a);
    return (idx >= 0) ? jal_word[idx] : default_word(a);
  endfunction

  function automatic word_t bus_order(input word_t w);
    return BUS_LITTLE_ENDIAN ? {w[7:0], w[15:8], w[23:16], w[31:24]} : w;
  endfunction

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // wishbone slave, lcg wait states before each ack
  always @(posedge CLK) begin
    wb_ack <= 1'b0;
    if (nRST && wb_cyc && wb_stb && !wb_ack) begin
      if (waits_left > 0) begin
        waits_left <= waits_left - 1;
      end else begin
        // reads only, whole words
        check_field("wb_we", 32'd0, wb_we);
        check_field("wb_sel", 32'hf, wb_sel);
        wb_ack     <= 1'b1;
        wb_dat_r   <= bus_order(mem_word(wb_adr));
        wait_rng   <= lcg_step(wait_rng);
        waits_left <= (max_wait == 0) ? 0 : int'(wait_rng[23:16]) % (max_wait + 1);
      end
    end
  end

  // consumer ready, random or always high
  always @(posedge CLK) begin
    ready_rng <= lcg_step(ready_rng);
    out_ready <= ready_random ? ready_rng[20] : 1'b1;
  end

  task automatic check_field(input string field, input word_t exp, input word_t act);
    checks++;
    assert (exp === act) else begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, field, exp, act);
      errors++;
    end
  endtask

  // predict the next transfer from the model pc, then advance
  task automatic check_transfer();
    int    idx;
    word_t exp_instr, exp_link;
    logic  exp_jump, exp_mal;
    addr_t next_pc;
    checks++;
    assert (!model_done) else begin
      $display("%s: unexpected transfer at pc %h after the misaligned token", test_name, out_pc);
      errors++;
    end
    if (!model_done) begin
      idx       = find_jal(model_pc);
      exp_instr = mem_word(model_pc);
      exp_jump  = (idx >= 0);
      exp_link  = exp_jump ? model_pc + 32'd4 : 32'd0;
      exp_mal   = (model_pc[1:0] != 2'b00);
      next_pc   = exp_jump ? model_pc + jal_imm[idx] : model_pc + 32'd4;
      // misaligned pc never reaches the bus, a bare token comes out
      if (exp_mal) begin
        exp_instr  = '0;
        exp_jump   = 1'b0;
        exp_link   = '0;
        model_done = 1'b1;
      end
      check_field("pc", model_pc, out_pc);
      check_field("instr", exp_instr, out_instr);
      check_field("link", exp_link, out_link);
      check_field("jump", exp_jump, out_jump);
      check_field("mal", exp_mal, out_mal);
      model_pc = next_pc;
    end
    xfers++;
    test_xfers++;
  endtask

  always @(posedge CLK) begin
    if (nRST && out_valid && out_ready) check_transfer();
  end

  // halt for two edges, model restarts once out_valid is already low
  task automatic pulse_halt();
    @(posedge CLK);
    halt <= 1'b1;
    @(posedge CLK);
    @(posedge CLK);
    model_pc   = RESET_PC;
    model_done = 1'b0;
    test_xfers = 0;
    halt <= 1'b0;
  endtask

  task automatic begin_test(input string name, input int waits, input logic ready_rand);
    pulse_halt();
    test_name = name;
    jal_count = 0;
    max_wait     <= waits;
    ready_random <= ready_rand;
  endtask

  task automatic place_jal(input addr_t a, input reg_idx_t rd, input word_t imm);
    jal_addr[jal_count] = a;
    jal_imm[jal_count]  = imm;
    jal_word[jal_count] = jal_encode(rd, imm);
    jal_count++;
  endtask

  task automatic wait_transfers(input int n);
    while (test_xfers < n) @(posedge CLK);
  endtask

  task automatic test_sequential();
    begin_test("test_sequential", 0, 1'b0);
    wait_transfers(16);
  endtask

  task automatic test_wait_states();
    begin_test("test_wait_states", 3, 1'b0);
    wait_transfers(16);
  endtask

  task automatic test_backpressure();
    begin_test("test_backpressure", 0, 1'b1);
    wait_transfers(24);
  endtask

  // jal to a jal, then back between the two
  task automatic test_jal_redirect();
    begin_test("test_jal_redirect", 2, 1'b1);
    place_jal(RESET_PC + 32'h8, 5'd1, 32'h40);
    place_jal(RESET_PC + 32'h48, 5'd5, 32'hffffffd0);
    wait_transfers(12);
  endtask

  task automatic test_misaligned();
    begin_test("test_misaligned", 1, 1'b1);
    place_jal(RESET_PC + 32'h4, 5'd1, 32'h102);
    wait_transfers(3);
    repeat (50) @(posedge CLK);
    check_field("transfer count", 32'd3, test_xfers);
  endtask

  task automatic test_halt_restart();
    begin_test("test_halt_restart", 2, 1'b1);
    place_jal(RESET_PC + 32'h10, 5'd1, 32'h20);
    wait_transfers(5);
    pulse_halt();
    wait_transfers(8);
  endtask

  initial begin
    nRST = 1'b0;
    halt = 1'b0;
    out_ready = 1'b0;
    wb_ack = 1'b0;
    wb_dat_r = '0;
    errors = 0;
    checks = 0;
    xfers = 0;
    test_xfers = 0;
    test_name = "reset";
    model_pc = RESET_PC;
    model_done = 1'b0;
    jal_count = 0;
    max_wait = 0;
    waits_left = 0;
    ready_random = 1'b0;
    wait_rng = 32'h4e7d;
    ready_rng = lcg_step(32'h4e7d);
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    test_sequential();
    test_wait_states();
    test_backpressure();
    test_jal_redirect();
    test_misaligned();
    test_halt_restart();
    // bound protocol assertions count their own failures
    errors += dut.u_assertions.failures;
    $display("checks %0d, errors %0d, transfers %0d", checks, errors, xfers);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // bound on total run time, scaled by the number of transfers
  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles in %s, errors so far %0d",
             WATCHDOG_CYCLES, test_name, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule
